// ==== hdl/alu_control.sv ====
`timescale 1ns/1ns

module alu_control import rv_decode_pkg::*; (
    input  alu_op_t    i_alu_op,
    input  logic [2:0] i_funct3,
    input  logic       i_funct7_5,
    output alu_ctrl_t  o_alu_ctrl
);

    logic is_rtype;

    assign is_rtype = (i_alu_op == ALU_RTYPE);

    always_comb begin
        case (i_alu_op)
            ALU_BRANCH: begin
                o_alu_ctrl = SUB;
            end
            ALU_RTYPE, ALU_ITYPE: begin
                case (i_funct3)
                    3'b000: begin
                        // SUB only exists in R-type, ADDI ignores bit 5
                        o_alu_ctrl = (is_rtype && i_funct7_5) ? SUB : ADD;
                    end
                    3'b001: o_alu_ctrl = SLL;
                    3'b010: o_alu_ctrl = SLT;
                    3'b011: o_alu_ctrl = SLTU;
                    3'b100: o_alu_ctrl = XOR;
                    3'b101: o_alu_ctrl = i_funct7_5 ? SRA : SRL;  // SRAI too
                    3'b110: o_alu_ctrl = OR;
                    default: o_alu_ctrl = AND;
                endcase
            end
            default: begin
                o_alu_ctrl = ADD;  // ALU_ADD and ALU_PASS_ADD
            end
        endcase
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module decode_stage import rv_decode_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [`RV_XLEN-1:0]  i_instr,
    input  logic                 i_flush,
    output logic                 o_stall,
    output logic                 o_branch,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_mem_to_reg,
    output logic                 o_reg_write,
    output logic                 o_pc_plus4,
    output logic                 o_csr_en,
    output logic                 o_ex,
    output alu_ctrl_t            o_alu_ctrl,
    output src_a_t               o_alu_src_a,
    output logic                 o_alu_src_b,
    output jump_t                o_jump,
    output logic [`RV_XLEN-1:0]  o_imm,
    output logic [`RV_REG_W-1:0] o_rd,
    output logic [`RV_REG_W-1:0] o_rs1,
    output logic [`RV_REG_W-1:0] o_rs2,
    output logic [2:0]           o_funct3
);

    logic                dec_branch;
    logic                dec_mem_read;
    logic                dec_mem_write;
    logic                dec_mem_to_reg;
    logic                dec_reg_write;
    logic                dec_pc_plus4;
    logic                dec_csr_en;
    logic                dec_ex;
    alu_op_t             dec_alu_op;
    src_a_t              dec_alu_src_a;
    logic                dec_alu_src_b;
    jump_t               dec_jump;
    imm_fmt_t            dec_imm_fmt;
    alu_ctrl_t           dec_alu_ctrl;
    logic [`RV_XLEN-1:0] dec_imm;

    hazard_unit u_hazard_unit (
        .i_rs1         (i_instr[19:15]),
        .i_rs2         (i_instr[24:20]),
        .i_ex_mem_read (o_mem_read),    // Load now in EX
        .i_ex_rd       (o_rd),
        .o_stall       (o_stall)
    );

    main_control u_main_control (
        .i_instr      (i_instr),
        .i_stall      (o_stall),
        .o_branch     (dec_branch),
        .o_mem_read   (dec_mem_read),
        .o_mem_write  (dec_mem_write),
        .o_mem_to_reg (dec_mem_to_reg),
        .o_reg_write  (dec_reg_write),
        .o_pc_plus4   (dec_pc_plus4),
        .o_csr_en     (dec_csr_en),
        .o_ex         (dec_ex),
        .o_alu_op     (dec_alu_op),
        .o_alu_src_a  (dec_alu_src_a),
        .o_alu_src_b  (dec_alu_src_b),
        .o_jump       (dec_jump),
        .o_imm_fmt    (dec_imm_fmt)
    );

    alu_control u_alu_control (
        .i_alu_op   (dec_alu_op),
        .i_funct3   (i_instr[14:12]),
        .i_funct7_5 (i_instr[30]),
        .o_alu_ctrl (dec_alu_ctrl)
    );

    imm_gen u_imm_gen (
        .i_instr   (i_instr),
        .i_imm_fmt (dec_imm_fmt),
        .o_imm     (dec_imm)
    );

    id_ex_reg u_id_ex_reg (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_flush      (i_flush),
        .i_stall      (o_stall),
        .i_branch     (dec_branch),
        .i_mem_read   (dec_mem_read),
        .i_mem_write  (dec_mem_write),
        .i_mem_to_reg (dec_mem_to_reg),
        .i_reg_write  (dec_reg_write),
        .i_pc_plus4   (dec_pc_plus4),
        .i_csr_en     (dec_csr_en),
        .i_ex         (dec_ex),
        .i_alu_ctrl   (dec_alu_ctrl),
        .i_alu_src_a  (dec_alu_src_a),
        .i_alu_src_b  (dec_alu_src_b),
        .i_jump       (dec_jump),
        .i_imm        (dec_imm),
        .i_rd         (i_instr[11:7]),
        .i_rs1        (i_instr[19:15]),
        .i_rs2        (i_instr[24:20]),
        .i_funct3     (i_instr[14:12]),
        .o_branch     (o_branch),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_mem_to_reg (o_mem_to_reg),
        .o_reg_write  (o_reg_write),
        .o_pc_plus4   (o_pc_plus4),
        .o_csr_en     (o_csr_en),
        .o_ex         (o_ex),
        .o_alu_ctrl   (o_alu_ctrl),
        .o_alu_src_a  (o_alu_src_a),
        .o_alu_src_b  (o_alu_src_b),
        .o_jump       (o_jump),
        .o_imm        (o_imm),
        .o_rd         (o_rd),
        .o_rs1        (o_rs1),
        .o_rs2        (o_rs2),
        .o_funct3     (o_funct3)
    );

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module hazard_unit (
    input  logic [`RV_REG_W-1:0] i_rs1,
    input  logic [`RV_REG_W-1:0] i_rs2,
    input  logic                 i_ex_mem_read,
    input  logic [`RV_REG_W-1:0] i_ex_rd,
    output logic                 o_stall
);

    logic rd_valid;
    logic rd_match;

    // x0 never carries a result
    assign rd_valid = (i_ex_rd != '0);

    // rs2 is compared even for formats that do not read it
    assign rd_match = (i_ex_rd == i_rs1) || (i_ex_rd == i_rs2);

    assign o_stall = i_ex_mem_read && rd_valid && rd_match;

endmodule

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module id_ex_reg import rv_decode_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_flush,
    input  logic                 i_stall,
    input  logic                 i_branch,
    input  logic                 i_mem_read,
    input  logic                 i_mem_write,
    input  logic                 i_mem_to_reg,
    input  logic                 i_reg_write,
    input  logic                 i_pc_plus4,
    input  logic                 i_csr_en,
    input  logic                 i_ex,
    input  alu_ctrl_t            i_alu_ctrl,
    input  src_a_t               i_alu_src_a,
    input  logic                 i_alu_src_b,
    input  jump_t                i_jump,
    input  logic [`RV_XLEN-1:0]  i_imm,
    input  logic [`RV_REG_W-1:0] i_rd,
    input  logic [`RV_REG_W-1:0] i_rs1,
    input  logic [`RV_REG_W-1:0] i_rs2,
    input  logic [2:0]           i_funct3,
    output logic                 o_branch,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_mem_to_reg,
    output logic                 o_reg_write,
    output logic                 o_pc_plus4,
    output logic                 o_csr_en,
    output logic                 o_ex,
    output alu_ctrl_t            o_alu_ctrl,
    output src_a_t               o_alu_src_a,
    output logic                 o_alu_src_b,
    output jump_t                o_jump,
    output logic [`RV_XLEN-1:0]  o_imm,
    output logic [`RV_REG_W-1:0] o_rd,
    output logic [`RV_REG_W-1:0] o_rs1,
    output logic [`RV_REG_W-1:0] o_rs2,
    output logic [2:0]           o_funct3
);

    logic bubble;

    // Flush wins over everything, a stall also drops rd
    assign bubble = i_flush || i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst || bubble) begin
            o_branch     <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write  <= 1'b0;
            o_pc_plus4   <= 1'b0;
            o_csr_en     <= 1'b0;
            o_ex         <= 1'b0;
            o_alu_ctrl   <= ADD;
            o_alu_src_a  <= SRC_A_RS1;
            o_alu_src_b  <= 1'b0;
            o_jump       <= JMP_NONE;
            o_imm        <= '0;
            o_rd         <= '0;  // Keeps the hazard from firing again
            o_rs1        <= '0;
            o_rs2        <= '0;
            o_funct3     <= 3'b000;
        end else begin
            o_branch     <= i_branch;
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_reg_write  <= i_reg_write;
            o_pc_plus4   <= i_pc_plus4;
            o_csr_en     <= i_csr_en;
            o_ex         <= i_ex;
            o_alu_ctrl   <= i_alu_ctrl;
            o_alu_src_a  <= i_alu_src_a;
            o_alu_src_b  <= i_alu_src_b;
            o_jump       <= i_jump;
            o_imm        <= i_imm;
            o_rd         <= i_rd;
            o_rs1        <= i_rs1;
            o_rs2        <= i_rs2;
            o_funct3     <= i_funct3;
        end
    end

    // Only ECALL/EBREAK may trap and write back at once
    a_ex_write_system: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_ex && o_reg_write) |-> o_csr_en)
        else $error("id_ex_reg: trapping slot writes back outside SYSTEM");

endmodule

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module imm_gen import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] i_instr,
    input  imm_fmt_t            i_imm_fmt,
    output logic [`RV_XLEN-1:0] o_imm
);

    logic sign;

    assign sign = i_instr[31];

    always_comb begin
        case (i_imm_fmt)
            IMM_I: begin
                o_imm = {{(`RV_XLEN-12){sign}}, i_instr[31:20]};
            end
            IMM_S: begin
                o_imm = {{(`RV_XLEN-12){sign}}, i_instr[31:25], i_instr[11:7]};
            end
            IMM_B: begin
                o_imm = {{(`RV_XLEN-13){sign}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};  // Halfword offset
            end
            IMM_U: begin
                o_imm = {{(`RV_XLEN-32){sign}}, i_instr[31:12], 12'd0};
            end
            IMM_J: begin
                o_imm = {{(`RV_XLEN-21){sign}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

// ==== hdl/main_control.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module main_control import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] i_instr,
    input  logic                i_stall,
    output logic                o_branch,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_to_reg,
    output logic                o_reg_write,
    output logic                o_pc_plus4,
    output logic                o_csr_en,
    output logic                o_ex,
    output alu_op_t             o_alu_op,
    output src_a_t              o_alu_src_a,
    output logic                o_alu_src_b,
    output jump_t               o_jump,
    output imm_fmt_t            o_imm_fmt
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [4:0]  rd;

    assign opcode  = i_instr[6:0];
    assign funct3  = i_instr[14:12];
    assign funct12 = i_instr[31:20];
    assign rs1     = i_instr[19:15];
    assign rd      = i_instr[11:7];

    always_comb begin
        o_branch     = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_reg_write  = 1'b0;
        o_pc_plus4   = 1'b0;
        o_csr_en     = 1'b0;
        o_ex         = 1'b0;
        o_alu_op     = ALU_ADD;
        o_alu_src_a  = SRC_A_RS1;
        o_alu_src_b  = 1'b0;
        o_jump       = JMP_NONE;
        o_imm_fmt    = IMM_NONE;

        if (!i_stall) begin  // Stalled slot stays all zero
            case (opcode)
                `RV_OP_R: begin
                    o_reg_write = 1'b1;
                    o_alu_op    = ALU_RTYPE;
                end
                `RV_OP_I: begin
                    o_reg_write = 1'b1;
                    o_alu_op    = ALU_ITYPE;
                    o_alu_src_b = 1'b1;
                    o_imm_fmt   = IMM_I;
                end
                `RV_OP_LOAD: begin
                    o_mem_read   = 1'b1;
                    o_mem_to_reg = 1'b1;
                    o_reg_write  = 1'b1;
                    o_alu_src_b  = 1'b1;
                    o_imm_fmt    = IMM_I;
                end
                `RV_OP_STORE: begin
                    o_mem_write = 1'b1;
                    o_alu_src_b = 1'b1;
                    o_imm_fmt   = IMM_S;
                end
                `RV_OP_BRANCH: begin
                    o_branch  = 1'b1;
                    o_alu_op  = ALU_BRANCH;  // Compare by subtract
                    o_imm_fmt = IMM_B;
                end
                `RV_OP_LUI: begin
                    o_reg_write = 1'b1;
                    o_alu_op    = ALU_PASS_ADD;
                    o_alu_src_a = SRC_A_ZERO;  // 0 + imm
                    o_alu_src_b = 1'b1;
                    o_imm_fmt   = IMM_U;
                end
                `RV_OP_AUIPC: begin
                    o_reg_write = 1'b1;
                    o_alu_op    = ALU_PASS_ADD;
                    o_alu_src_a = SRC_A_PC;
                    o_alu_src_b = 1'b1;
                    o_imm_fmt   = IMM_U;
                end
                `RV_OP_JAL: begin
                    o_reg_write = 1'b1;
                    o_jump      = JMP_JAL;
                    o_pc_plus4  = 1'b1;  // Link value
                    o_imm_fmt   = IMM_J;
                end
                `RV_OP_JALR: begin
                    o_reg_write = 1'b1;
                    o_alu_op    = ALU_PASS_ADD;  // Target is rs1 + imm
                    o_alu_src_b = 1'b1;
                    o_jump      = JMP_JALR;
                    o_pc_plus4  = 1'b1;
                    o_imm_fmt   = IMM_I;
                end
                `RV_OP_FENCE: begin
                    // Treated as a NOP
                end
                `RV_OP_SYSTEM: begin
                    o_reg_write = 1'b1;
                    o_csr_en    = 1'b1;
                    o_imm_fmt   = IMM_I;  // CSR address field
                    // ECALL and EBREAK trap, CSR accesses do not
                    o_ex = (funct3 == 3'b000) && (rs1 == 5'd0) && (rd == 5'd0) &&
                           (funct12 == 12'd0 || funct12 == 12'd1);
                end
                default: begin
                    o_ex = 1'b1;  // Illegal opcode
                end
            endcase
        end
    end

    always_comb begin
        assert ($onehot0({o_mem_read, o_mem_write}))
            else $error("main_control: load and store raised together");
    end

endmodule

// ==== hdl/rv_decode_pkg.sv ====
package rv_decode_pkg;

    typedef enum logic [2:0] {
        ALU_ADD      = 3'b000,
        ALU_BRANCH   = 3'b001,
        ALU_RTYPE    = 3'b010,
        ALU_ITYPE    = 3'b011,
        ALU_PASS_ADD = 3'b100  // LUI, AUIPC, JALR
    } alu_op_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_t;

    typedef enum logic [1:0] {
        JMP_NONE = 2'd0,
        JMP_JAL  = 2'd1,
        JMP_JALR = 2'd2
    } jump_t;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_t;

endpackage

// ==== include/rv_decode_cfg.svh ====
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

`define RV_XLEN         32
`define RV_REG_W        5

// RV32I base opcodes
`define RV_OP_R         7'b0110011
`define RV_OP_I         7'b0010011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_SYSTEM    7'b1110011
`define RV_OP_FENCE     7'b0001111

`endif

// ==== project.f ====
+incdir+include
hdl/rv_decode_pkg.sv
hdl/main_control.sv
hdl/alu_control.sv
hdl/imm_gen.sv
hdl/hazard_unit.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
verification/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_decode_stage \
    -Mdir obj_dir \
    -o sim_decode_stage

./obj_dir/sim_decode_stage | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== verification/tb_decode_stage.sv ====
`timescale 1ns/1ns

`include "rv_decode_cfg.svh"

module tb_decode_stage import rv_decode_pkg::*; ();

    localparam int MAX_CYCLES = 3000;  // 1500 random plus directed, one stall per pair at most

    typedef struct packed {
        logic        branch;
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic        reg_write;
        logic        pc_plus4;
        logic        csr_en;
        logic        ex;
        alu_ctrl_t   alu_ctrl;
        src_a_t      alu_src_a;
        logic        alu_src_b;
        jump_t       jump;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
    } stage_t;

    logic                 i_clk;
    logic                 i_rst;
    logic [`RV_XLEN-1:0]  i_instr;
    logic                 i_flush;
    logic                 o_stall;
    logic                 o_branch;
    logic                 o_mem_read;
    logic                 o_mem_write;
    logic                 o_mem_to_reg;
    logic                 o_reg_write;
    logic                 o_pc_plus4;
    logic                 o_csr_en;
    logic                 o_ex;
    alu_ctrl_t            o_alu_ctrl;
    src_a_t               o_alu_src_a;
    logic                 o_alu_src_b;
    jump_t                o_jump;
    logic [`RV_XLEN-1:0]  o_imm;
    logic [`RV_REG_W-1:0] o_rd;
    logic [`RV_REG_W-1:0] o_rs1;
    logic [`RV_REG_W-1:0] o_rs2;
    logic [2:0]           o_funct3;

    stage_t      exp;
    logic        exp_valid;
    logic        stall_exp;
    logic        hold;
    string       exp_name;
    string       cur_name;
    int          check_count;
    int          error_count;
    int          cycle_count;
    integer      seed;
    logic [31:0] rnd;
    logic [31:0] sel;
    int          n;

    decode_stage dut (.*);

    always #5 i_clk = ~i_clk;

    function automatic alu_ctrl_t ref_alu(input logic is_r, input logic [2:0] f3,
                                          input logic f7_5);
        case (f3)
            3'd0: ref_alu = (is_r && f7_5) ? SUB : ADD;  // No SUBI in RV32I
            3'd1: ref_alu = SLL;
            3'd2: ref_alu = SLT;
            3'd3: ref_alu = SLTU;
            3'd4: ref_alu = XOR;
            3'd5: ref_alu = f7_5 ? SRA : SRL;
            3'd6: ref_alu = OR;
            default: ref_alu = AND;
        endcase
    endfunction

    function automatic stage_t ref_decode(input logic [31:0] instr);
        stage_t s;
        logic [31:0] imm_i;
        s = '0;
        imm_i = 32'($signed(instr[31:20]));
        s.rd = instr[11:7];
        s.rs1 = instr[19:15];
        s.rs2 = instr[24:20];
        s.funct3 = instr[14:12];
        case (instr[6:0])
            `RV_OP_R: begin
                s.reg_write = 1'b1;
                s.alu_ctrl = ref_alu(1'b1, instr[14:12], instr[30]);
            end
            `RV_OP_I: begin
                s.reg_write = 1'b1;
                s.alu_src_b = 1'b1;
                s.alu_ctrl = ref_alu(1'b0, instr[14:12], instr[30]);
                s.imm = imm_i;
            end
            `RV_OP_LOAD: begin
                s.mem_read = 1'b1;
                s.mem_to_reg = 1'b1;
                s.reg_write = 1'b1;
                s.alu_src_b = 1'b1;
                s.imm = imm_i;
            end
            `RV_OP_STORE: begin
                s.mem_write = 1'b1;
                s.alu_src_b = 1'b1;
                s.imm = 32'($signed({instr[31:25], instr[11:7]}));
            end
            `RV_OP_BRANCH: begin
                s.branch = 1'b1;
                s.alu_ctrl = SUB;
                s.imm = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
            end
            `RV_OP_LUI, `RV_OP_AUIPC: begin
                s.reg_write = 1'b1;
                s.alu_src_a = (instr[5]) ? SRC_A_ZERO : SRC_A_PC;  // Bit 5 tells LUI apart
                s.alu_src_b = 1'b1;
                s.imm = {instr[31:12], 12'h000};
            end
            `RV_OP_JAL: begin
                s.reg_write = 1'b1;
                s.jump = JMP_JAL;
                s.pc_plus4 = 1'b1;
                s.imm = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
            end
            `RV_OP_JALR: begin
                s.reg_write = 1'b1;
                s.alu_src_b = 1'b1;
                s.jump = JMP_JALR;
                s.pc_plus4 = 1'b1;
                s.imm = imm_i;
            end
            `RV_OP_FENCE: begin
                s.imm = '0;
            end
            `RV_OP_SYSTEM: begin
                s.reg_write = 1'b1;
                s.csr_en = 1'b1;
                s.imm = imm_i;
                s.ex = (instr[19:7] == 13'd0) && (instr[31:21] == 11'd0);  // ECALL, EBREAK
            end
            default: begin
                s.ex = 1'b1;
            end
        endcase
        return s;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_R};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'd0, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] idx, input logic [6:0] raw);
        case (idx)
            4'd0: return `RV_OP_R;
            4'd1: return `RV_OP_I;
            4'd2: return `RV_OP_LOAD;
            4'd3: return `RV_OP_STORE;
            4'd4: return `RV_OP_BRANCH;
            4'd5: return `RV_OP_LUI;
            4'd6: return `RV_OP_AUIPC;
            4'd7: return `RV_OP_JAL;
            4'd8: return `RV_OP_JALR;
            4'd9: return `RV_OP_SYSTEM;
            4'd10: return `RV_OP_FENCE;
            default: return raw;  // Mostly illegal
        endcase
    endfunction

    task automatic check_bit(input string test, input string field, input logic e,
                             input logic a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("** Error %s %s: expected %0b, actual %0b", test, field, e, a);
        end
    endtask

    task automatic check_alu_ctrl(input string test, input alu_ctrl_t e, input alu_ctrl_t a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("** Error %s o_alu_ctrl: expected %s, actual %s", test, e.name(), a.name());
        end
    endtask

    task automatic check_src_a(input string test, input src_a_t e, input src_a_t a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("** Error %s o_alu_src_a: expected %s, actual %s", test, e.name(), a.name());
        end
    endtask

    task automatic check_jump(input string test, input jump_t e, input jump_t a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("** Error %s o_jump: expected %s, actual %s", test, e.name(), a.name());
        end
    endtask

    task automatic check_word(input string test, input string field, input logic [31:0] e,
                              input logic [31:0] a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("** Error %s %s: expected %08h, actual %08h", test, field, e, a);
        end
    endtask

    task automatic compare_stage(input string test, input stage_t e);
        check_bit(test, "o_branch", e.branch, o_branch);
        check_bit(test, "o_mem_read", e.mem_read, o_mem_read);
        check_bit(test, "o_mem_write", e.mem_write, o_mem_write);
        check_bit(test, "o_mem_to_reg", e.mem_to_reg, o_mem_to_reg);
        check_bit(test, "o_reg_write", e.reg_write, o_reg_write);
        check_bit(test, "o_pc_plus4", e.pc_plus4, o_pc_plus4);
        check_bit(test, "o_csr_en", e.csr_en, o_csr_en);
        check_bit(test, "o_ex", e.ex, o_ex);
        check_alu_ctrl(test, e.alu_ctrl, o_alu_ctrl);
        check_src_a(test, e.alu_src_a, o_alu_src_a);
        check_bit(test, "o_alu_src_b", e.alu_src_b, o_alu_src_b);
        check_jump(test, e.jump, o_jump);
        check_word(test, "o_imm", e.imm, o_imm);
        check_word(test, "o_rd", {27'd0, e.rd}, {27'd0, o_rd});
        check_word(test, "o_rs1", {27'd0, e.rs1}, {27'd0, o_rs1});
        check_word(test, "o_rs2", {27'd0, e.rs2}, {27'd0, o_rs2});
        check_word(test, "o_funct3", {29'd0, e.funct3}, {29'd0, o_funct3});
    endtask

    // Waits out a predicted stall so the held instruction is decoded again
    task automatic issue(input string name, input logic [31:0] instr, input logic flush);
        @(posedge i_clk);
        while (hold) begin
            i_flush <= 1'b0;
            @(posedge i_clk);
        end
        cur_name = name;
        i_instr <= instr;
        i_flush <= flush;
    endtask

    // Checks the slot captured at the last edge, then predicts the next one
    always @(negedge i_clk) begin
        stall_exp = exp_valid && exp.mem_read && (exp.rd != 5'd0) &&
                    ((exp.rd == i_instr[19:15]) || (exp.rd == i_instr[24:20]));
        if (exp_valid) begin
            compare_stage(exp_name, exp);
            check_bit(cur_name, "o_stall", stall_exp, o_stall);
        end
        hold = stall_exp;
        if (i_rst || i_flush || stall_exp) begin
            exp = '0;
        end else begin
            exp = ref_decode(i_instr);
        end
        exp_name = cur_name;
        exp_valid = 1'b1;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_instr = 32'h0000_0013;
        i_flush = 1'b0;
        exp = '0;
        exp_valid = 1'b0;
        hold = 1'b0;
        cur_name = "reset";
        exp_name = "reset";
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        seed = 32'hfa838f54;

        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;

        for (int f = 0; f < 8; f++) begin
            issue("r_type", r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3), 1'b0);
            issue("i_type", i_type(12'hf83, 5'd1, 3'(f), 5'd4, `RV_OP_I), 1'b0);
        end
        issue("r_sub", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), 1'b0);
        issue("r_sra", r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3), 1'b0);
        issue("i_srli", i_type(12'h003, 5'd1, 3'd5, 5'd4, `RV_OP_I), 1'b0);
        issue("i_addi_b30", i_type(12'h400, 5'd1, 3'd0, 5'd4, `RV_OP_I), 1'b0);
        issue("load", i_type(12'hffc, 5'd2, 3'd2, 5'd5, `RV_OP_LOAD), 1'b0);
        issue("store", s_type(12'h808, 5'd6, 5'd9), 1'b0);
        issue("branch", b_type(13'h1ff0, 5'd2, 5'd1), 1'b0);
        issue("lui", {20'habcde, 5'd7, `RV_OP_LUI}, 1'b0);
        issue("auipc", {20'h80001, 5'd8, `RV_OP_AUIPC}, 1'b0);
        issue("jal", j_type(21'h1ff800, 5'd1), 1'b0);
        issue("jalr", i_type(12'h00c, 5'd5, 3'd0, 5'd1, `RV_OP_JALR), 1'b0);
        issue("fence", 32'h0ff0_000f, 1'b0);
        issue("ecall", 32'h0000_0073, 1'b0);
        issue("ebreak", 32'h0010_0073, 1'b0);
        issue("csrrw", i_type(12'h300, 5'd1, 3'd1, 5'd2, `RV_OP_SYSTEM), 1'b0);
        issue("illegal_7f", 32'h0000_007f, 1'b0);
        issue("illegal_zero", 32'h0000_0000, 1'b0);

        // Load-use pairs, then a load to x0
        issue("lu_load_rs1", i_type(12'h000, 5'd1, 3'd2, 5'd7, `RV_OP_LOAD), 1'b0);
        issue("lu_use_rs1", r_type(7'h00, 5'd4, 5'd7, 3'd0, 5'd3), 1'b0);
        issue("lu_load_rs2", i_type(12'h000, 5'd1, 3'd2, 5'd9, `RV_OP_LOAD), 1'b0);
        issue("lu_use_rs2", s_type(12'h004, 5'd9, 5'd2), 1'b0);
        issue("lu_load_x0", i_type(12'h000, 5'd1, 3'd2, 5'd0, `RV_OP_LOAD), 1'b0);
        issue("lu_use_x0", r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd3), 1'b0);
        issue("flush", i_type(12'h001, 5'd1, 3'd0, 5'd1, `RV_OP_I), 1'b1);
        issue("after_flush", 32'h0000_0013, 1'b0);

        n = 0;
        while (n < 1500) begin
            rnd = $random(seed);
            sel = $random(seed);
            if (sel[3:0] < 4'd2) begin
                issue("rand_load", i_type(rnd[31:20], rnd[19:15], 3'd2, rnd[11:7],
                      `RV_OP_LOAD), 1'b0);
                issue("rand_use", r_type(7'h00, rnd[24:20], rnd[11:7], rnd[14:12],
                      rnd[19:15]), sel[4]);
                n = n + 2;
            end else begin
                issue("rand", {rnd[31:7], pick_opcode(sel[11:8], sel[18:12])},
                      (sel[23:20] == 4'd0));
                n = n + 1;
            end
        end

        issue("drain", 32'h0000_0013, 1'b0);
        issue("drain", 32'h0000_0013, 1'b0);
        repeat (2) @(posedge i_clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
